//--- Bender.yml
package:
  name: axil_prefetch

sources:
  # Design, in compile order
  - files:
      - common/fetch_pkg.sv
      - bus_req/fetch_req.sv
      - bus_req/flush_tracker.sv
      - logic/insn_fifo.sv
      - logic/insn_unpack.sv
      - logic/fetch_top.sv

  # Testbench
  - target: test
    files:
      - tb/axil_rom_slave.sv
      - tb/fetch_tb.sv

//--- bus_req/fetch_req.sv
/*
 * Fetch request issue
 * Drives the AXI-lite read address channel with sequential word
 * addresses. Issue is throttled by the words requested but not yet
 * popped, and a new PC seen during a stalled request is held back
 */
module fetch_req
	import fetch_pkg::*;
(
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	input  logic              i_new_pc,
	input  logic [ADDR_W-1:0] i_pc,
	input  logic              i_clear_cache,
	input  logic              i_arready,
	input  logic              i_pop,
	input  logic              i_out_busy,
	input  logic              i_full_bus,
	input  logic              i_flush_request,
	output axil_ar_t          o_ar
);

	logic              restart;
	logic              ar_valid;
	logic [ADDR_W-1:0] ar_addr;
	logic              ar_open;
	logic              ar_fire;
	logic              pending_new_pc;
	logic [ADDR_W-1:0] pending_pc;
	logic [CNT_W-1:0]  fill;
	logic [CNT_W:0]    committed;

	assign restart = i_new_pc || i_clear_cache;
	// Channel free for a new address
	assign ar_open = !ar_valid || i_arready;
	assign ar_fire = ar_valid && i_arready;

	// Words requested, held on the channel, or still in the output
	assign committed = {1'b0, fill} + (CNT_W+1)'(ar_valid) + (CNT_W+1)'(i_out_busy);

	// Words requested for this stream and not yet popped
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || restart)
			fill <= '0;
		else
		begin
			// A flushed request never reaches the FIFO
			case ({ar_fire && !i_flush_request, i_pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// ARVALID
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			ar_valid <= 1'b0;
		else if (ar_open)
		begin
			if (i_clear_cache || i_full_bus)
				ar_valid <= 1'b0;
			// Fresh stream, nothing committed yet
			else if (i_new_pc)
				ar_valid <= 1'b1;
			else if (committed >= (CNT_W+1)'(FETCH_LIMIT))
				ar_valid <= 1'b0;
			else
				ar_valid <= 1'b1;
		end
	end

	// New PC arrived while the channel was stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_clear_cache)
			pending_new_pc <= 1'b0;
		else if (ar_open)
			pending_new_pc <= 1'b0;
		else if (i_new_pc)
			pending_new_pc <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			pending_pc <= i_pc;
	end

	// ARADDR
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			ar_addr <= '0;
		else if (ar_open)
		begin
			if (i_new_pc)
				ar_addr <= i_pc;
			else if (pending_new_pc)
				ar_addr <= pending_pc;
			else if (ar_valid)
			begin
				// Next word, aligned
				ar_addr[ADDR_W-1:WORD_LSB] <= ar_addr[ADDR_W-1:WORD_LSB]
					+ (ADDR_W-WORD_LSB)'(1);
				ar_addr[WORD_LSB-1:0] <= '0;
			end
		end
	end

	assign o_ar.valid = ar_valid;
	assign o_ar.addr = ar_addr;

	// Stalled request keeps its address
	a_ar_hold: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		o_ar.valid && !i_arready |=> o_ar.valid && $stable(o_ar.addr));

endmodule

//--- bus_req/flush_tracker.sv
/*
 * Outstanding read and flush tracking
 * Counts reads on the bus, flags when the counter nears its limit,
 * and on a restart counts down the returns of the old stream
 */
module flush_tracker
	import fetch_pkg::*;
(
	input  logic     S_AXI_ACLK,
	input  logic     fifo_reset,
	input  logic     i_new_pc,
	input  logic     i_clear_cache,
	input  axil_ar_t i_ar,
	input  logic     i_arready,
	input  logic     i_rvalid,
	output logic     o_full_bus,
	output logic     o_flushing,
	output logic     o_flush_request
);

	logic             restart;
	logic             ar_fire;
	logic [CNT_W-1:0] outstanding;
	logic [CNT_W-1:0] next_outstanding;
	logic [CNT_W-1:0] new_flushcount;
	logic [CNT_W-1:0] flushcount;

	assign restart = i_new_pc || i_clear_cache;
	assign ar_fire = i_ar.valid && i_arready;

	always_comb
	begin
		next_outstanding = outstanding;
		case ({ar_fire, i_rvalid})
			2'b10: next_outstanding = outstanding + 1'b1;
			2'b01: next_outstanding = outstanding - 1'b1;
			default: next_outstanding = outstanding;
		endcase
	end

	// Everything already sent plus a held request that goes out anyway
	assign new_flushcount = outstanding + CNT_W'(i_ar.valid) - CNT_W'(i_rvalid);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			outstanding <= '0;
			o_full_bus <= 1'b0;
		end
		else
		begin
			outstanding <= next_outstanding;
			// One below the top half of the counter
			o_full_bus <= (next_outstanding >= CNT_W'((1 << (CNT_W-1)) - 1));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Flush of stale returns
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			flushcount <= '0;
			o_flushing <= 1'b0;
			o_flush_request <= 1'b0;
		end
		else if (restart)
		begin
			flushcount <= new_flushcount;
			o_flushing <= (new_flushcount != '0);
			// Stalled request still belongs to the old stream
			o_flush_request <= i_ar.valid && !i_arready;
		end
		else
		begin
			if (i_rvalid && (flushcount != '0))
			begin
				flushcount <= flushcount - 1'b1;
				o_flushing <= (flushcount > CNT_W'(1));
			end
			if (i_arready)
				o_flush_request <= 1'b0;
		end
	end

	a_flush_flag: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		o_flushing == (flushcount != '0));

	// No return without a read and no read past the counter top
	a_no_wrap: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		!((outstanding == '0) && i_rvalid && !ar_fire)
		&& !((&outstanding) && ar_fire && !i_rvalid));

endmodule

//--- common/fetch_pkg.sv
/*
 * Shared definitions for the AXI-lite instruction prefetcher
 * Bus and instruction widths, fetch limits, counter sizes and the
 * packed types passed between the request, FIFO and unpack blocks
 */
package fetch_pkg;

	// Bus geometry
	localparam int ADDR_W = 32;
	localparam int BUS_W = 64;
	localparam int INSN_W = 32;
	localparam int INSNS_PER_WORD = 2;
	// Byte offset bits within one bus word
	localparam int WORD_LSB = 3;

	// Words buffered or in flight, at most
	localparam int FETCH_LIMIT = 8;
	// FIFO of 8 bus words
	localparam int LGFIFO = 3;
	// Outstanding and flush counters, LGFIFO+4 plus a spare bit
	localparam int CNT_W = 8;

	////////////////////////////////////////////////////////////////////////////
	// Bus word, seen raw or as two instruction lanes
	////////////////////////////////////////////////////////////////////////////

	// Lane 0 sits in the low half
	typedef union packed {
		logic [BUS_W-1:0] raw;
		logic [INSNS_PER_WORD-1:0][INSN_W-1:0] lane;
	} bus_word_u;

	// One FIFO slot
	typedef struct packed {
		logic illegal;
		bus_word_u data;
	} fifo_entry_t;

	////////////////////////////////////////////////////////////////////////////
	// Channel and CPU-side bundles
	////////////////////////////////////////////////////////////////////////////

	// Read address channel
	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] addr;
	} axil_ar_t;

	// Read data channel, RREADY is always high
	typedef struct packed {
		logic valid;
		logic [BUS_W-1:0] data;
		logic [1:0] resp;
	} axil_r_t;

	// Instruction handed to the CPU
	typedef struct packed {
		logic valid;
		logic illegal;
		logic [ADDR_W-1:0] pc;
		logic [INSN_W-1:0] insn;
	} fetch_out_t;

endpackage

//--- logic/fetch_top.sv
/*
 * AXI-lite instruction prefetcher
 * Issues sequential 64-bit reads with several in flight, buffers the
 * returns and hands 32-bit instructions to the CPU. A new PC or a
 * cache clear restarts the stream and discards stale returns
 */
module fetch_top
	import fetch_pkg::*;
(
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	// CPU side
	input  logic              i_new_pc,
	input  logic [ADDR_W-1:0] i_pc,
	input  logic              i_clear_cache,
	input  logic              i_ready,
	output fetch_out_t        o_fetch,
	// Read address channel, unprivileged instruction access
	output axil_ar_t          o_ar,
	input  logic              i_arready,
	// Read data channel, every beat accepted
	input  axil_r_t           i_r
);

	logic        full_bus;
	logic        flushing;
	logic        flush_request;
	logic        pop;
	logic        rd;
	logic        empty;
	logic        out_busy;
	fifo_entry_t head;

	////////////////////////////////////////////////////////////////////////////
	// Bus side
	////////////////////////////////////////////////////////////////////////////

	fetch_req u_req (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.fifo_reset      (fifo_reset),
		.i_new_pc        (i_new_pc),
		.i_pc            (i_pc),
		.i_clear_cache   (i_clear_cache),
		.i_arready       (i_arready),
		.i_pop           (pop),
		.i_out_busy      (out_busy),
		.i_full_bus      (full_bus),
		.i_flush_request (flush_request),
		.o_ar            (o_ar)
	);

	// Watches the same handshake the request block drives
	flush_tracker u_flush (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.fifo_reset      (fifo_reset),
		.i_new_pc        (i_new_pc),
		.i_clear_cache   (i_clear_cache),
		.i_ar            (o_ar),
		.i_arready       (i_arready),
		.i_rvalid        (i_r.valid),
		.o_full_bus      (full_bus),
		.o_flushing      (flushing),
		.o_flush_request (flush_request)
	);

	////////////////////////////////////////////////////////////////////////////
	// Buffer and CPU side
	////////////////////////////////////////////////////////////////////////////

	insn_fifo u_fifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_new_pc      (i_new_pc),
		.i_clear_cache (i_clear_cache),
		.i_r           (i_r),
		.i_flushing    (flushing),
		.i_rd          (rd),
		.o_head        (head),
		.o_empty       (empty),
		.o_pop         (pop)
	);

	insn_unpack u_unpack (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_new_pc      (i_new_pc),
		.i_pc          (i_pc),
		.i_clear_cache (i_clear_cache),
		.i_ready       (i_ready),
		.i_head        (head),
		.i_empty       (empty),
		.o_rd          (rd),
		.o_out_busy    (out_busy),
		.o_fetch       (o_fetch)
	);

endmodule

//--- logic/insn_fifo.sv
/*
 * Returned word FIFO
 * Byte-swaps each 32-bit lane of the read data and stores it with
 * its bus error flag in an 8-deep circular buffer. Emptied on restart
 */
module insn_fifo
	import fetch_pkg::*;
(
	input  logic        S_AXI_ACLK,
	input  logic        fifo_reset,
	input  logic        i_new_pc,
	input  logic        i_clear_cache,
	input  axil_r_t     i_r,
	input  logic        i_flushing,
	input  logic        i_rd,
	output fifo_entry_t o_head,
	output logic        o_empty,
	output logic        o_pop
);

	logic          restart;
	logic          wr_en;
	logic          rd_en;
	logic          full;
	logic [LGFIFO:0] wr_ptr;
	logic [LGFIFO:0] rd_ptr;
	bus_word_u     swapped;
	fifo_entry_t   mem [0:(1<<LGFIFO)-1];

	assign restart = i_new_pc || i_clear_cache;

	// Big-endian instructions, each lane reversed on its own
	always_comb
	begin
		for (int l = 0; l < INSNS_PER_WORD; l++)
		begin
			for (int b = 0; b < INSN_W/8; b++)
				swapped.lane[l][(INSN_W/8-1-b)*8 +: 8] = i_r.data[l*INSN_W + b*8 +: 8];
		end
	end

	// Stale returns dropped during a flush
	assign wr_en = i_r.valid && !i_flushing;
	assign rd_en = i_rd && !o_empty;

	assign o_empty = (wr_ptr == rd_ptr);
	// Pointers differ only in the wrap bit
	assign full = (wr_ptr[LGFIFO] != rd_ptr[LGFIFO])
		&& (wr_ptr[LGFIFO-1:0] == rd_ptr[LGFIFO-1:0]);

	////////////////////////////////////////////////////////////////////////////
	// Pointers and storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || restart)
			wr_ptr <= '0;
		else if (wr_en)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || restart)
			rd_ptr <= '0;
		else if (rd_en)
			rd_ptr <= rd_ptr + 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_en)
		begin
			// RRESP bit 1 marks SLVERR or DECERR
			mem[wr_ptr[LGFIFO-1:0]].illegal <= i_r.resp[1];
			mem[wr_ptr[LGFIFO-1:0]].data <= swapped;
		end
	end

	// Head visible the cycle after it is written
	assign o_head = mem[rd_ptr[LGFIFO-1:0]];
	assign o_pop = rd_en;

	// Request throttle upstream keeps room for every return
	a_no_overflow: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		!(wr_en && full));

endmodule

//--- logic/insn_unpack.sv
/*
 * Instruction unpacker
 * Takes bus words from the FIFO and hands out one 32-bit instruction
 * per accepted cycle, with its PC. A word entered at an odd lane skips
 * lane 0. A bus error latches the illegal flag until the next restart
 */
module insn_unpack
	import fetch_pkg::*;
(
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	input  logic              i_new_pc,
	input  logic [ADDR_W-1:0] i_pc,
	input  logic              i_clear_cache,
	input  logic              i_ready,
	input  fifo_entry_t       i_head,
	input  logic              i_empty,
	output logic              o_rd,
	output logic              o_out_busy,
	output fetch_out_t        o_fetch
);

	logic              restart;
	logic              shift;
	logic              out_valid;
	logic              out_illegal;
	logic [1:0]        out_fill;
	logic [ADDR_W-1:0] out_pc;
	bus_word_u         out_word;

	assign restart = i_new_pc || i_clear_cache;

	// Odd-lane entry only for the first word after a jump
	assign shift = out_valid ? 1'b0 : out_pc[WORD_LSB-1];

	// Next word wanted when idle or on the last lane
	assign o_rd = !out_valid || (i_ready && (out_fill <= 2'd1));

	// Output still holds a word the CPU has not finished
	assign o_out_busy = out_valid && (!i_ready || (out_fill > 2'd1));

	////////////////////////////////////////////////////////////////////////////
	// Lane count and valid
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || restart)
			out_fill <= 2'd0;
		else if (o_rd)
			out_fill <= i_empty ? 2'd0 : 2'(INSNS_PER_WORD) - {1'b0, shift};
		else if (i_ready && (out_fill != 2'd0))
			out_fill <= out_fill - 2'd1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || restart)
			out_valid <= 1'b0;
		else if (!out_valid || i_ready)
			out_valid <= (o_rd && !i_empty) || (out_fill > (out_valid ? 2'd1 : 2'd0));
	end

	// Word shifts down one lane per accepted instruction
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_rd)
		begin
			if (shift)
				out_word.raw <= i_head.data.raw >> INSN_W;
			else
				out_word <= i_head.data;
		end
		else if (i_ready)
			out_word.raw <= out_word.raw >> INSN_W;
	end

	////////////////////////////////////////////////////////////////////////////
	// PC and error flag
	////////////////////////////////////////////////////////////////////////////

	// Frozen once the stream turns illegal
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			out_pc <= '0;
		else if (i_new_pc)
			out_pc <= i_pc;
		else if (out_valid && i_ready && !out_illegal)
			out_pc <= {out_pc[ADDR_W-1:2] + (ADDR_W-2)'(1), 2'b00};
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || restart)
			out_illegal <= 1'b0;
		else if (!out_illegal && o_rd && !i_empty)
			out_illegal <= i_head.illegal;
	end

	assign o_fetch.valid = out_valid;
	assign o_fetch.illegal = out_illegal;
	assign o_fetch.pc = out_pc;
	assign o_fetch.insn = out_word.lane[0];

	// CPU sees the same instruction until it takes it
	a_out_hold: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		o_fetch.valid && !i_ready && !restart |=> $stable(o_fetch));

endmodule

//--- tb/axil_rom_slave.sv
/*
 * AXI-lite read-only memory model
 * Accepts read addresses after a random stall and returns each 64-bit
 * word in order after a random delay. Every 32-bit lane carries a
 * pattern of its byte address. Words in the error window answer SLVERR
 */
module axil_rom_slave
	import fetch_pkg::*;
#(
	parameter logic [ADDR_W-1:0] ERR_LO = 32'h0000_0200,
	parameter logic [ADDR_W-1:0] ERR_HI = 32'h0000_0240
)
(
	input  logic     S_AXI_ACLK,
	input  logic     fifo_reset,
	input  axil_ar_t i_ar,
	output logic     o_arready,
	output axil_r_t  o_r
);

	logic [ADDR_W-1:0] addr_q[$];
	int unsigned       due_q[$];
	int unsigned       cycle;
	int unsigned       stall;

	// Lane contents fold the address onto itself
	function automatic logic [INSN_W-1:0] lane_pattern(input logic [ADDR_W-1:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'hA5C3_0F69;
	endfunction

	// Bus idle until the first clock
	initial
	begin
		o_arready <= 1'b0;
		o_r <= '0;
	end

	always @(posedge S_AXI_ACLK)
	begin
		logic [ADDR_W-1:0] base;
		if (fifo_reset)
		begin
			o_arready <= 1'b0;
			o_r <= '0;
			stall = 0;
			cycle = 0;
			addr_q.delete();
			due_q.delete();
		end
		else
		begin
			cycle = cycle + 1;
			// Next stall of 0 to 3 cycles after each accepted address
			if (i_ar.valid && o_arready)
			begin
				addr_q.push_back(i_ar.addr);
				due_q.push_back(cycle + $urandom_range(1, 6));
				stall = $urandom_range(0, 3);
				o_arready <= (stall == 0);
			end
			else if (!o_arready)
			begin
				if (stall <= 1)
					o_arready <= 1'b1;
				if (stall != 0)
					stall = stall - 1;
			end
			// A later read never overtakes the head
			o_r.valid <= 1'b0;
			if ((due_q.size() != 0) && (cycle >= due_q[0]))
			begin
				base = addr_q.pop_front();
				base[WORD_LSB-1:0] = '0;
				due_q.delete(0);
				o_r.valid <= 1'b1;
				o_r.data <= {lane_pattern(base + 32'd4), lane_pattern(base)};
				o_r.resp <= ((base >= ERR_LO) && (base < ERR_HI)) ? 2'b10 : 2'b00;
			end
		end
	end

endmodule

//--- tb/fetch_tb.sv
/*
 * Testbench for the AXI-lite instruction prefetcher
 * Sequential fetch, odd-lane jumps, random CPU stalls, restarts with
 * reads in flight and a pass through a bus error window. Every taken
 * instruction is checked against a model of the ROM contents
 */
module fetch_tb
	import fetch_pkg::*;
();

	localparam logic [ADDR_W-1:0] ERR_LO = 32'h0000_0200;
	localparam logic [ADDR_W-1:0] ERR_HI = 32'h0000_0240;
	localparam int TIMEOUT = 3000;

	logic              S_AXI_ACLK;
	logic              fifo_reset;
	logic              i_new_pc;
	logic [ADDR_W-1:0] i_pc;
	logic              i_clear_cache;
	logic              i_ready;
	logic              i_arready;
	axil_ar_t          o_ar;
	axil_r_t           i_r;
	fetch_out_t        o_fetch;

	// Model state
	logic              rand_ready;
	logic [ADDR_W-1:0] exp_pc;
	logic              illegal_seen;
	logic              cleared;
	logic              hold_pending;
	logic              stale_held;
	logic              ar_stalled;
	axil_ar_t          ar_prev;
	fetch_out_t        held;
	int                accepted;
	int                cur_out;
	int                stale_out;

	initial S_AXI_ACLK = 1'b0;
	always #50 S_AXI_ACLK = ~S_AXI_ACLK;

	fetch_top dut0 (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_new_pc      (i_new_pc),
		.i_pc          (i_pc),
		.i_clear_cache (i_clear_cache),
		.i_ready       (i_ready),
		.o_fetch       (o_fetch),
		.o_ar          (o_ar),
		.i_arready     (i_arready),
		.i_r           (i_r)
	);

	axil_rom_slave #(.ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) u_rom (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_ar       (o_ar),
		.o_arready  (i_arready),
		.o_r        (i_r)
	);

	////////////////////////////////////////////////////////////////////////////
	// Checks and model
	////////////////////////////////////////////////////////////////////////////

	task automatic check_eq(input string what, input logic [95:0] got, input logic [95:0] exp);
		if (got !== exp)
		begin
			$display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s, at time %0t", why, $time);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	// Lane picked by PC bit 2 and stored big-endian
	function automatic logic [INSN_W-1:0] expected_insn(input logic [ADDR_W-1:0] pc);
		logic [ADDR_W-1:0] a;
		logic [INSN_W-1:0] v;
		a = {pc[ADDR_W-1:WORD_LSB], pc[2], 2'b00};
		v = a ^ {a[15:0], a[31:16]} ^ 32'hA5C3_0F69;
		return {v[7:0], v[15:8], v[23:16], v[31:24]};
	endfunction

	function automatic logic in_error_window(input logic [ADDR_W-1:0] pc);
		logic [ADDR_W-1:0] base;
		base = {pc[ADDR_W-1:WORD_LSB], 3'b000};
		return (base >= ERR_LO) && (base < ERR_HI);
	endfunction

	// CPU back-pressure
	always @(posedge S_AXI_ACLK)
	begin
		if (rand_ready)
			i_ready <= ($urandom_range(0, 2) != 0);
		else
			i_ready <= 1'b1;
	end

	// Monitor sees values from before the edge
	always @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			exp_pc = '0;
			illegal_seen = 1'b0;
			cleared = 1'b0;
			hold_pending = 1'b0;
			stale_held = 1'b0;
			ar_stalled = 1'b0;
			cur_out = 0;
			stale_out = 0;
		end
		else
		begin
			if (hold_pending)
				check_eq("o_fetch while stalled", o_fetch, held);
			// Stalled read request keeps valid and address
			if (ar_stalled)
				check_eq("o_ar while stalled", o_ar, ar_prev);
			ar_stalled = o_ar.valid && !i_arready;
			ar_prev = o_ar;
			// A held read at a restart still goes out for the old stream
			if (o_ar.valid && i_arready)
			begin
				if (stale_held)
				begin
					stale_out++;
					stale_held = 1'b0;
				end
				else
					cur_out++;
			end
			if (i_r.valid)
			begin
				if (stale_out > 0)
					stale_out--;
				else
					cur_out--;
			end
			if (cur_out > FETCH_LIMIT)
				abort_run("More than FETCH_LIMIT reads outstanding at the responder");
			if (cur_out < 0)
				abort_run("Read data returned with no read outstanding");
			hold_pending = 1'b0;
			if (i_new_pc || i_clear_cache)
			begin
				stale_out = stale_out + cur_out;
				cur_out = 0;
				if (o_ar.valid && !i_arready)
					stale_held = 1'b1;
				cleared = !i_new_pc;
				if (i_new_pc)
				begin
					exp_pc = i_pc;
					illegal_seen = 1'b0;
				end
			end
			else if (o_fetch.valid && i_ready)
			begin
				if (cleared)
					abort_run("Instruction delivered after a cache clear");
				check_eq("o_fetch.pc", o_fetch.pc, exp_pc);
				check_eq("o_fetch.illegal", o_fetch.illegal,
					illegal_seen || in_error_window(exp_pc));
				// Frozen PC once illegal
				if (o_fetch.illegal)
					illegal_seen = 1'b1;
				else
				begin
					check_eq("o_fetch.insn", o_fetch.insn, expected_insn(exp_pc));
					exp_pc = exp_pc + 32'd4;
				end
				accepted++;
			end
			else if (o_fetch.valid)
			begin
				hold_pending = 1'b1;
				held = o_fetch;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic wait_accepts(input int n);
		int target;
		int cycles;
		target = accepted + n;
		cycles = 0;
		while (accepted < target)
		begin
			@(negedge S_AXI_ACLK);
			cycles++;
			if (cycles > TIMEOUT)
				abort_run("Timed out waiting for instructions");
		end
	endtask

	task automatic wait_for_illegal();
		int cycles;
		cycles = 0;
		while (!illegal_seen)
		begin
			@(negedge S_AXI_ACLK);
			cycles++;
			if (cycles > TIMEOUT)
				abort_run("Timed out waiting for the illegal flag");
		end
	endtask

	task automatic jump_to(input logic [ADDR_W-1:0] pc);
		@(posedge S_AXI_ACLK);
		i_new_pc <= 1'b1;
		i_pc <= pc;
		@(posedge S_AXI_ACLK);
		i_new_pc <= 1'b0;
	endtask

	// Clear and then jump a cycle or two later
	task automatic clear_then_jump(input logic [ADDR_W-1:0] pc, input int gap);
		@(posedge S_AXI_ACLK);
		i_clear_cache <= 1'b1;
		@(posedge S_AXI_ACLK);
		i_clear_cache <= 1'b0;
		repeat (gap - 1) @(posedge S_AXI_ACLK);
		jump_to(pc);
	endtask

	initial
	begin
		int unsigned k;
		void'($urandom(73576));
		fifo_reset = 1'b1;
		i_new_pc = 1'b0;
		i_pc = '0;
		i_clear_cache = 1'b0;
		i_ready = 1'b0;
		rand_ready = 1'b0;
		accepted = 0;
		repeat (5) @(posedge S_AXI_ACLK);
		fifo_reset <= 1'b0;
		// Out of reset the stream starts at 0
		wait_accepts(12);
		jump_to(32'h0000_1000);
		wait_accepts(40);
		rand_ready = 1'b1;
		wait_accepts(60);
		// Upper lane first
		jump_to(32'h0000_2004);
		wait_accepts(30);
		// Restarts mid-stream
		for (k = 0; k < 12; k++)
		begin
			wait_accepts($urandom_range(1, 8));
			repeat ($urandom_range(0, 3)) @(posedge S_AXI_ACLK);
			if (k % 3 == 2)
				clear_then_jump(32'h3000 + ($urandom_range(0, 255) << 2),
					$urandom_range(1, 2));
			else
				jump_to(32'h3000 + ($urandom_range(0, 255) << 2));
		end
		wait_accepts(30);
		// Into the error window and out again by a new PC
		jump_to(32'h0000_01F4);
		wait_for_illegal();
		wait_accepts(10);
		jump_to(32'h0000_4000);
		wait_accepts(20);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- vlog.f
common/fetch_pkg.sv
bus_req/fetch_req.sv
bus_req/flush_tracker.sv
logic/insn_fifo.sv
logic/insn_unpack.sv
logic/fetch_top.sv
tb/axil_rom_slave.sv
tb/fetch_tb.sv
